// File: hw/muldiv_params.svh
// muldiv sizing macros: data width and divider iteration count
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// one machine word
`define MD_XLEN 32

// restoring divider retires one quotient bit per step
`define MD_DIV_STEPS `MD_XLEN

`endif

// File: hw/muldiv_pkg.sv
// muldiv op encoding and the decoded request handed to the arithmetic units
`default_nettype none

`include "muldiv_params.svh"

package muldiv_pkg;

    // core-side op strobe, OP_NONE on idle cycles
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_MULT  = 3'd1,
        OP_MULTU = 3'd2,
        OP_DIV   = 3'd3,
        OP_DIVU  = 3'd4,
        OP_MTHI  = 3'd5,
        OP_MTLO  = 3'd6
    } md_op_e;

    typedef struct packed {
        logic                mul_go;    // multiply this cycle
        logic                div_go;    // start a divide
        logic                is_signed; // signed form of mult/div
        logic                mt_hi;     // move a into HI
        logic                mt_lo;     // move b into LO
        logic [`MD_XLEN-1:0] a;
        logic [`MD_XLEN-1:0] b;
    } md_req_t;

endpackage

`default_nettype wire

// File: hw/hilo_pkg.sv
// HI/LO register write bundle shared by all result producers
`default_nettype none

`include "muldiv_params.svh"

package hilo_pkg;

    typedef struct packed {
        logic                we_hi; // write HI
        logic                we_lo; // write LO
        logic [`MD_XLEN-1:0] hi;
        logic [`MD_XLEN-1:0] lo;
    } hilo_wr_t;

endpackage

`default_nettype wire

// File: hw/muldiv_decode.sv
// muldiv input decode: op strobe to request flags, divide busy and ready level
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

module muldiv_decode (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire muldiv_pkg::md_op_e op,
    input  wire [`MD_XLEN-1:0]   in0,
    input  wire [`MD_XLEN-1:0]   in1,
    input  wire                  div_done,
    output muldiv_pkg::md_req_t  req,
    output logic                 ready
);

    logic busy_q;
    logic busy_d;

    always_comb
    begin
        req   = '0;
        req.a = in0;
        req.b = in1;
        case (op)
            muldiv_pkg::OP_MULT:
            begin
                req.mul_go    = 1'b1;
                req.is_signed = 1'b1;
            end
            muldiv_pkg::OP_MULTU: req.mul_go = 1'b1;
            muldiv_pkg::OP_DIV:
            begin
                req.div_go    = 1'b1;
                req.is_signed = 1'b1;
            end
            muldiv_pkg::OP_DIVU: req.div_go = 1'b1;
            muldiv_pkg::OP_MTHI:
            begin
                req.mt_hi = 1'b1;
                req.b     = in0; // moved value on both halves
            end
            muldiv_pkg::OP_MTLO:
            begin
                req.mt_lo = 1'b1;
                req.b     = in0;
            end
            default: ;
        endcase
    end

    // busy spans issue up to and including the done cycle
    assign busy_d = req.div_go ? 1'b1 : (div_done ? 1'b0 : busy_q);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q <= 1'b0;
            ready  <= 1'b0;
        end
        else
        begin
            busy_q <= busy_d;
            ready  <= !busy_d;
        end
    end

    // core must hold off while a divide is running
    a_no_op_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy_q |-> op == muldiv_pkg::OP_NONE)
        else $error("op issued while divider busy");

    a_done_only_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        div_done |-> busy_q)
        else $error("divider done without a divide in flight");

endmodule

`default_nettype wire

// File: hw/mul_unit.sv
// two-stage 32x32 signed/unsigned multiplier, also carries MTHI/MTLO writes
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

module mul_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire muldiv_pkg::md_req_t req,
    output hilo_pkg::hilo_wr_t  mul_wr
);

    logic signed [`MD_XLEN:0]     a_ext;
    logic signed [`MD_XLEN:0]     b_ext;
    logic signed [2*`MD_XLEN-1:0] prod;

    logic                we_hi_q;
    logic                we_lo_q;
    logic [`MD_XLEN-1:0] hi_q;
    logic [`MD_XLEN-1:0] lo_q;

    // one extra bit so unsigned operands stay positive
    assign a_ext = {req.is_signed & req.a[`MD_XLEN-1], req.a};
    assign b_ext = {req.is_signed & req.b[`MD_XLEN-1], req.b};
    assign prod  = a_ext * b_ext; // low 64 bits are exact for both forms

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            we_hi_q <= 1'b0;
            we_lo_q <= 1'b0;
        end
        else
        begin
            we_hi_q <= req.mul_go | req.mt_hi;
            we_lo_q <= req.mul_go | req.mt_lo;
        end
    end

    always_ff @(posedge clk)
    begin
        hi_q <= req.mul_go ? prod[2*`MD_XLEN-1:`MD_XLEN] : req.a;
        lo_q <= req.mul_go ? prod[`MD_XLEN-1:0] : req.b;
    end

    always_comb
    begin
        mul_wr.we_hi = we_hi_q;
        mul_wr.we_lo = we_lo_q;
        mul_wr.hi    = hi_q;
        mul_wr.lo    = lo_q;
    end

endmodule

`default_nettype wire

// File: hw/div_unit.sv
// iterative restoring divider, signed/unsigned, one-cycle done pulse at the end
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

module div_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire muldiv_pkg::md_req_t req,
    output hilo_pkg::hilo_wr_t  div_wr,
    output logic                done
);

    localparam int CW = $clog2(`MD_DIV_STEPS);
    localparam logic [CW-1:0] LAST = CW'(`MD_DIV_STEPS - 1);

    logic                run_q;
    logic [CW-1:0]       cnt_q;

    logic [`MD_XLEN-1:0] quo_q; // dividend shifts out, quotient shifts in
    logic [`MD_XLEN-1:0] rem_q;
    logic [`MD_XLEN-1:0] dvs_q;
    logic                q_neg_q;
    logic                r_neg_q;
    logic                dz_q;

    logic [`MD_XLEN-1:0] mag_a;
    logic [`MD_XLEN-1:0] mag_b;
    logic [`MD_XLEN+1:0] trial;
    logic                fits;

    // magnitudes; 0x80000000 maps onto itself as 2^31
    assign mag_a = (req.is_signed && req.a[`MD_XLEN-1]) ? -req.a : req.a;
    assign mag_b = (req.is_signed && req.b[`MD_XLEN-1]) ? -req.b : req.b;

    // shifted partial remainder minus divisor, sign bit says restore
    assign trial = {1'b0, rem_q, quo_q[`MD_XLEN-1]} - {2'b00, dvs_q};
    assign fits  = !trial[`MD_XLEN+1];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            run_q <= 1'b0;
            cnt_q <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= run_q && (cnt_q == LAST);
            if (req.div_go)
            begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end
            else if (run_q)
            begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == LAST)
                    run_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req.div_go)
        begin
            quo_q   <= mag_a;
            rem_q   <= '0;
            dvs_q   <= mag_b;
            q_neg_q <= req.is_signed & (req.a[`MD_XLEN-1] ^ req.b[`MD_XLEN-1]);
            r_neg_q <= req.is_signed & req.a[`MD_XLEN-1]; // remainder follows dividend
            dz_q    <= (req.b == '0);
        end
        else if (run_q)
        begin
            if (fits)
                rem_q <= trial[`MD_XLEN-1:0];
            else
                rem_q <= {rem_q[`MD_XLEN-2:0], quo_q[`MD_XLEN-1]};
            quo_q <= {quo_q[`MD_XLEN-2:0], fits};
        end
    end

    // sign fix on the way out, valid while done is high
    always_comb
    begin
        div_wr.we_hi = done;
        div_wr.we_lo = done;
        div_wr.hi    = r_neg_q ? -rem_q : rem_q; // zero divisor leaves the dividend here
        if (dz_q)
            div_wr.lo = '1;
        else
            div_wr.lo = q_neg_q ? -quo_q : quo_q;
    end

    a_no_go_while_running: assert property (@(posedge clk) disable iff (!rst_n)
        run_q |-> !req.div_go)
        else $error("divide started while divider running");

endmodule

`default_nettype wire

// File: hw/hilo_regs.sv
// HI/LO register pair with divide-priority write arbitration and read mux
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

module hilo_regs (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire hilo_pkg::hilo_wr_t mul_wr,
    input  wire hilo_pkg::hilo_wr_t div_wr,
    input  wire                     read_hi,
    output logic [`MD_XLEN-1:0]     result
);

    logic [`MD_XLEN-1:0] hi_q;
    logic [`MD_XLEN-1:0] lo_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hi_q <= '0;
            lo_q <= '0;
        end
        else
        begin
            if (div_wr.we_hi)
                hi_q <= div_wr.hi; // divider wins a clash
            else if (mul_wr.we_hi)
                hi_q <= mul_wr.hi;

            if (div_wr.we_lo)
                lo_q <= div_wr.lo;
            else if (mul_wr.we_lo)
                lo_q <= mul_wr.lo;
        end
    end

    assign result = read_hi ? hi_q : lo_q;

    a_single_writer: assert property (@(posedge clk) disable iff (!rst_n)
        !((div_wr.we_hi || div_wr.we_lo) && (mul_wr.we_hi || mul_wr.we_lo)))
        else $error("multiplier and divider wrote HI/LO together");

endmodule

`default_nettype wire

// File: hw/muldiv_top.sv
// muldiv top: decode, multiplier, divider and HI/LO registers
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

module muldiv_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire muldiv_pkg::md_op_e op,
    input  wire [`MD_XLEN-1:0]      in0,
    input  wire [`MD_XLEN-1:0]      in1,
    input  wire                     read_hi,
    output logic [`MD_XLEN-1:0]     result,
    output logic                    ready
);

    muldiv_pkg::md_req_t req;
    hilo_pkg::hilo_wr_t  mul_wr;
    hilo_pkg::hilo_wr_t  div_wr;
    logic                div_done;

    muldiv_decode decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op),
        .in0      (in0),
        .in1      (in1),
        .div_done (div_done),
        .req      (req),
        .ready    (ready)
    );

    mul_unit mul_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .mul_wr (mul_wr)
    );

    div_unit div_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .div_wr (div_wr),
        .done   (div_done)
    );

    hilo_regs hilo_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mul_wr  (mul_wr),
        .div_wr  (div_wr),
        .read_hi (read_hi),
        .result  (result)
    );

endmodule

`default_nettype wire

// File: tb/muldiv_model.svh
// muldiv reference model: random source, biased operands, products and divides
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// classic 32-bit LCG constants
function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// corner values turn up in about three draws out of eight
function automatic logic [31:0] biased_operand(input logic [31:0] sel, input logic [31:0] raw);
    case (sel[31:29])
        3'd0: return 32'h0000_0000;
        3'd1: return 32'hffff_ffff;
        3'd2: return 32'h8000_0000;
        3'd3: return {28'd0, raw[31:28]}; // small positive
        default: return raw;
    endcase
endfunction

// {hi, lo} of the full product
function automatic logic [63:0] full_product(input logic [31:0] a, input logic [31:0] b,
                                             input logic sgn);
    logic [63:0] ax;
    logic [63:0] bx;
    ax = sgn ? {{32{a[31]}}, a} : {32'd0, a};
    bx = sgn ? {{32{b[31]}}, b} : {32'd0, b};
    return ax * bx;
endfunction

// {remainder, quotient}, quotient truncated toward zero
function automatic logic [63:0] quot_rem(input logic [31:0] a, input logic [31:0] b,
                                         input logic sgn);
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] q;
    logic [31:0] r;
    if (b == 32'd0)
        return {a, 32'hffff_ffff}; // divide by zero
    ma = (sgn && a[31]) ? 32'd0 - a : a;
    mb = (sgn && b[31]) ? 32'd0 - b : b;
    q  = ma / mb;
    r  = ma % mb;
    if (sgn && (a[31] != b[31]))
        q = 32'd0 - q;
    if (sgn && a[31])
        r = 32'd0 - r; // remainder keeps the dividend's sign
    return {r, q};
endfunction

`endif

// File: tb/tb_muldiv.sv
// muldiv testbench with directed and random ops checked against a HI/LO model
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"
`include "muldiv_model.svh"

module tb_muldiv;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 400;
    localparam int READY_LIMIT  = `MD_DIV_STEPS + 4;
    localparam int WATCHDOG_NS  = NUM_RANDOM * (`MD_DIV_STEPS + 8) * 2 * CLK_HALF
                                  + RESET_CYCLES * 2 * CLK_HALF;

    logic                clk;
    logic                rst_n;
    muldiv_pkg::md_op_e  op;
    logic [`MD_XLEN-1:0] in0;
    logic [`MD_XLEN-1:0] in1;
    logic                read_hi;
    logic [`MD_XLEN-1:0] result;
    logic                ready;

    logic [31:0]         model_hi;
    logic [31:0]         model_lo;
    logic [31:0]         lcg_state;

    muldiv_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .op      (op),
        .in0     (in0),
        .in1     (in1),
        .read_hi (read_hi),
        .result  (result),
        .ready   (ready)
    );

    always #(CLK_HALF) clk = ~clk;

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic draw_random(output logic [31:0] v);
        lcg_state = lcg_step(lcg_state);
        v = lcg_state;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_hilo();
        read_hi = 1'b1;
        #1;
        check_value("result(HI)", result, model_hi);
        read_hi = 1'b0;
        #1;
        check_value("result(LO)", result, model_lo);
    endtask

    task automatic apply_model(input muldiv_pkg::md_op_e o, input logic [31:0] a,
                               input logic [31:0] b);
        case (o)
            muldiv_pkg::OP_MULT:  {model_hi, model_lo} = full_product(a, b, 1'b1);
            muldiv_pkg::OP_MULTU: {model_hi, model_lo} = full_product(a, b, 1'b0);
            muldiv_pkg::OP_DIV:   {model_hi, model_lo} = quot_rem(a, b, 1'b1);
            muldiv_pkg::OP_DIVU:  {model_hi, model_lo} = quot_rem(a, b, 1'b0);
            muldiv_pkg::OP_MTHI:  model_hi = a;
            muldiv_pkg::OP_MTLO:  model_lo = a;
            default: ;
        endcase
    endtask

    // issue one op, wait for it to land, then compare both registers
    task automatic run_op(input muldiv_pkg::md_op_e o, input logic [31:0] a,
                          input logic [31:0] b);
        int cycles;
        op  = o;
        in0 = a;
        in1 = b;
        next_cycle();
        op = muldiv_pkg::OP_NONE;
        if (o == muldiv_pkg::OP_DIV || o == muldiv_pkg::OP_DIVU)
        begin
            check_value("ready", {31'd0, ready}, 32'd0);
            cycles = 1;
            while (ready !== 1'b1)
            begin
                if (cycles >= READY_LIMIT)
                begin
                    $display("ready stayed low for %0d cycles after a divide", cycles);
                    $display("TEST FAIL");
                    $fatal(1, "divider never finished");
                end
                next_cycle();
                cycles++;
            end
            check_value("ready latency", cycles, `MD_DIV_STEPS + 2);
        end
        else
        begin
            check_value("ready", {31'd0, ready}, 32'd1); // no busy for mult or move
            next_cycle(); // write lands at the end of the cycle after issue
        end
        apply_model(o, a, b);
        check_hilo();
    endtask

    // two multiplies in consecutive cycles
    task automatic multiply_pair(input logic [31:0] a0, input logic [31:0] b0,
                                 input logic [31:0] a1, input logic [31:0] b1);
        op  = muldiv_pkg::OP_MULT;
        in0 = a0;
        in1 = b0;
        next_cycle();
        op  = muldiv_pkg::OP_MULTU;
        in0 = a1;
        in1 = b1;
        next_cycle();
        op = muldiv_pkg::OP_NONE;
        apply_model(muldiv_pkg::OP_MULT, a0, b0);
        check_hilo();
        next_cycle();
        apply_model(muldiv_pkg::OP_MULTU, a1, b1);
        check_hilo();
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("simulation ran past %0d ns without finishing", WATCHDOG_NS);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [31:0]        r_op;
        logic [31:0]        r_sa;
        logic [31:0]        r_a;
        logic [31:0]        r_sb;
        logic [31:0]        r_b;
        muldiv_pkg::md_op_e rnd_op;
        clk       = 1'b0;
        rst_n     = 1'b0;
        op        = muldiv_pkg::OP_NONE;
        in0       = '0;
        in1       = '0;
        read_hi   = 1'b0;
        model_hi  = '0;
        model_lo  = '0;
        lcg_state = 32'h4f4f_017a;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        check_value("ready", {31'd0, ready}, 32'd1);
        check_hilo();

        run_op(muldiv_pkg::OP_MULT, 32'd3, 32'hffff_fffb);
        run_op(muldiv_pkg::OP_MULT, 32'h8000_0000, 32'h8000_0000);
        run_op(muldiv_pkg::OP_MULT, 32'h8000_0000, 32'hffff_ffff);
        run_op(muldiv_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        multiply_pair(32'hffff_fff9, 32'd9, 32'h1234_5678, 32'h9abc_def0);

        run_op(muldiv_pkg::OP_DIV, 32'hffff_fff9, 32'd2);
        run_op(muldiv_pkg::OP_DIV, 32'd7, 32'hffff_fffe);
        run_op(muldiv_pkg::OP_DIV, 32'hffff_fff9, 32'hffff_fffe);
        run_op(muldiv_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff); // overflow corner
        run_op(muldiv_pkg::OP_DIVU, 32'hffff_ffff, 32'd2);
        run_op(muldiv_pkg::OP_DIVU, 32'h8000_0000, 32'hffff_ffff);
        run_op(muldiv_pkg::OP_DIV, 32'hffff_fffb, 32'd0);
        run_op(muldiv_pkg::OP_DIVU, 32'h1234_5678, 32'd0);

        run_op(muldiv_pkg::OP_MTHI, 32'hdead_beef, 32'h0);
        run_op(muldiv_pkg::OP_MTLO, 32'h0bad_f00d, 32'hffff_ffff); // in1 must be ignored

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            draw_random(r_op);
            draw_random(r_sa);
            draw_random(r_a);
            draw_random(r_sb);
            draw_random(r_b);
            rnd_op = muldiv_pkg::md_op_e'(3'(1 + r_op[31:16] % 6));
            run_op(rnd_op, biased_operand(r_sa, r_a), biased_operand(r_sb, r_b));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
+incdir+tb
hw/muldiv_pkg.sv
hw/hilo_pkg.sv
hw/muldiv_decode.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/hilo_regs.sv
hw/muldiv_top.sv
tb/tb_muldiv.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_muldiv -Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/Vtb_muldiv); echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)
